//--- tcdm_streamer.f
src/streamer_pkg.sv
src/streamer_regs.sv
src/stream_addressgen.sv
src/tcdm_source.sv
src/tcdm_sink.sv
src/streamer_router.sv
src/tcdm_streamer.sv
bench/tb_memory_model.sv
bench/tb_tcdm_streamer.sv

//--- run_sim.sh
#!/bin/sh
# build the streamer testbench with Verilator, run it, and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_tcdm_streamer -f tcdm_streamer.f \
  && ./obj_dir/Vtb_tcdm_streamer > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- bench/tb_tcdm_streamer.sv
// memory streamer testbench
// register access, strided loads to each stream, a conv store and its read-back,
// all checked by concurrent assertions against a reference memory
`timescale 1ns/10ps
`default_nettype none

module tb_tcdm_streamer;

  import streamer_pkg::*;

  localparam int                MAX_CYCLES = 4000;
  localparam logic [DATA_W-1:0] PATTERN    = 32'hA5A5_0000;
  localparam logic [APB_AW-1:0] BAD_ADDR   = 8'h20;  // outside the register map
  localparam logic [ADDR_W-1:0] ST_BASE    = 16'h0040;
  localparam logic [ADDR_W-1:0] ST_STRIDE  = 16'h0002;
  localparam logic [LEN_W-1:0]  ST_LEN     = 16'd6;

  logic              clk = 1'b0;
  logic              reset;
  logic [APB_AW-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [DATA_W-1:0] pwdata;
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic              mem_req;
  logic              mem_we;
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic              mem_gnt;
  logic [DATA_W-1:0] mem_rdata;
  logic              mem_rvalid;
  logic              feat_valid;
  logic [DATA_W-1:0] feat_data;
  logic              weight_valid;
  logic [DATA_W-1:0] weight_data;
  logic              norm_valid;
  logic [DATA_W-1:0] norm_data;
  logic              stream_ready = 1'b0;  // shared by all three load streams
  logic              conv_valid;
  logic [DATA_W-1:0] conv_data;
  logic              conv_ready;

  // job state kept by the testbench
  logic              load_active;
  logic              store_active;
  logic              job_is_store;
  logic              job_seen = 1'b0;
  logic              stall_en;
  logic [1:0]        load_sel;
  logic [ADDR_W-1:0] job_base;
  logic [ADDR_W-1:0] job_stride;
  logic [LEN_W-1:0]  job_len;
  logic [ADDR_W-1:0] shadow_base;
  logic [LEN_W-1:0]  shadow_len;
  logic [ADDR_W-1:0] shadow_stride;
  logic [LEN_W-1:0]  beat_cnt;
  logic [LEN_W-1:0]  wr_cnt;
  logic [DATA_W-1:0] conv_sent [0:7];
  logic [DATA_W-1:0] ref_mem [2**ADDR_W];
  integer            seed = 32'h881b_056a;
  int                cycle_cnt = 0;

  logic              apb_access;
  logic              apb_rd;
  logic              start_wr;
  logic              load_valid;
  logic              load_fire;
  logic [DATA_W-1:0] load_data;
  logic [2:0]        exp_onehot;
  logic [ADDR_W-1:0] exp_load_addr;
  logic [DATA_W-1:0] exp_load;
  logic [ADDR_W-1:0] exp_st_addr;
  logic [DATA_W-1:0] exp_wdata;

  always #2 clk = ~clk;

  tcdm_streamer u_tcdm_streamer (
    .clk_i          ( clk          ),
    .reset_i        ( reset        ),
    .paddr_i        ( paddr        ),
    .psel_i         ( psel         ),
    .penable_i      ( penable      ),
    .pwrite_i       ( pwrite       ),
    .pwdata_i       ( pwdata       ),
    .prdata_o       ( prdata       ),
    .pready_o       ( pready       ),
    .pslverr_o      ( pslverr      ),
    .mem_req_o      ( mem_req      ),
    .mem_we_o       ( mem_we       ),
    .mem_addr_o     ( mem_addr     ),
    .mem_wdata_o    ( mem_wdata    ),
    .mem_gnt_i      ( mem_gnt      ),
    .mem_rdata_i    ( mem_rdata    ),
    .mem_rvalid_i   ( mem_rvalid   ),
    .feat_valid_o   ( feat_valid   ),
    .feat_data_o    ( feat_data    ),
    .feat_ready_i   ( stream_ready ),
    .weight_valid_o ( weight_valid ),
    .weight_data_o  ( weight_data  ),
    .weight_ready_i ( stream_ready ),
    .norm_valid_o   ( norm_valid   ),
    .norm_data_o    ( norm_data    ),
    .norm_ready_i   ( stream_ready ),
    .conv_valid_i   ( conv_valid   ),
    .conv_data_i    ( conv_data    ),
    .conv_ready_o   ( conv_ready   )
  );

  tb_memory_model u_memory (
    .clk_i    ( clk        ),
    .reset_i  ( reset      ),
    .req_i    ( mem_req    ),
    .we_i     ( mem_we     ),
    .addr_i   ( mem_addr   ),
    .wdata_i  ( mem_wdata  ),
    .gnt_o    ( mem_gnt    ),
    .rdata_o  ( mem_rdata  ),
    .rvalid_o ( mem_rvalid )
  );

  assign apb_access    = psel & penable;
  assign apb_rd        = apb_access & ~pwrite;
  assign start_wr      = apb_access & pwrite & (paddr == REG_CTRL) & pwdata[CTRL_START_BIT];
  assign load_valid    = feat_valid | weight_valid | norm_valid;
  assign load_fire     = load_valid & stream_ready;
  assign load_data     = feat_valid ? feat_data : (weight_valid ? weight_data : norm_data);
  assign exp_onehot    = load_active ? (3'b001 << load_sel) : 3'b000;
  assign exp_load_addr = job_base + job_stride * beat_cnt;  // beat i sits at base + i*stride
  assign exp_load      = ref_mem[exp_load_addr];
  assign exp_st_addr   = job_base + job_stride * wr_cnt;
  assign exp_wdata     = conv_sent[wr_cnt[2:0]];

  // beats and writes seen since the last launch
  always @(posedge clk) begin
    if (reset || start_wr) begin
      beat_cnt <= '0;
      wr_cnt   <= '0;
    end else begin
      if (load_fire)
        beat_cnt <= beat_cnt + 1'b1;
      if (mem_req && mem_gnt && mem_we)
        wr_cnt <= wr_cnt + 1'b1;
    end
    if (start_wr)
      job_seen <= 1'b1;
  end

  always @(negedge clk) begin
    if (stall_en)
      stream_ready <= 1'($random(seed));
    else
      stream_ready <= 1'b1;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  task automatic report_fail(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  assert property (@(posedge clk) $fell(reset) |->
    !mem_req && !feat_valid && !weight_valid && !norm_valid && !conv_ready)
    else report_fail("outputs not idle after reset");
  assert property (@(posedge clk) disable iff (reset) apb_access |->
    (pready && pslverr == (paddr == BAD_ADDR)))
    else report_fail("pready or pslverr wrong in an APB access");
  assert property (@(posedge clk) disable iff (reset) (apb_rd && paddr == REG_BASE) |->
    prdata == DATA_W'(shadow_base)) else report_fail("base readback mismatch");
  assert property (@(posedge clk) disable iff (reset) (apb_rd && paddr == REG_LEN) |->
    prdata == DATA_W'(shadow_len)) else report_fail("len readback mismatch");
  assert property (@(posedge clk) disable iff (reset) (apb_rd && paddr == REG_STRIDE) |->
    prdata == DATA_W'(shadow_stride)) else report_fail("stride readback mismatch");
  assert property (@(posedge clk) disable iff (reset)
    (apb_rd && paddr == REG_STATUS && !job_seen) |-> prdata[1:0] == 2'b00)
    else report_fail("busy or done set before any job");
  assert property (@(posedge clk) disable iff (reset)
    (apb_rd && paddr == REG_STATUS && prdata[1]) |->
    (!prdata[0] && (job_is_store ? wr_cnt == job_len : beat_cnt == job_len)))
    else report_fail("done reported with a wrong beat count or still busy");
  assert property (@(posedge clk) disable iff (reset) load_valid |->
    {norm_valid, weight_valid, feat_valid} == exp_onehot)
    else report_fail("valid raised on a stream that is not selected");
  assert property (@(posedge clk) disable iff (reset) load_fire |->
    (beat_cnt < job_len && load_data == exp_load))
    else report_fail("load beat data or order wrong");
  assert property (@(posedge clk) disable iff (reset) (load_valid && !stream_ready) |=>
    (load_valid && $stable(load_data))) else report_fail("load beat changed while stalled");
  assert property (@(posedge clk) disable iff (reset) mem_req |->
    (mem_we ? store_active : load_active)) else report_fail("memory request outside its job");
  assert property (@(posedge clk) disable iff (reset) (mem_req && !mem_gnt) |=>
    (mem_req && $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata)))
    else report_fail("request changed while waiting for grant");
  assert property (@(posedge clk) disable iff (reset) (mem_req && mem_gnt && mem_we) |->
    (wr_cnt < job_len && mem_addr == exp_st_addr && mem_wdata == exp_wdata))
    else report_fail("store write address or data wrong");
  assert property (@(posedge clk) disable iff (reset) conv_ready |-> store_active)
    else report_fail("conv_ready high outside a store job");

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    paddr   = addr;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    case (addr)
      REG_BASE:   shadow_base   = data[ADDR_W-1:0];
      REG_LEN:    shadow_len    = data[LEN_W-1:0];
      REG_STRIDE: shadow_stride = data[ADDR_W-1:0];
      default: ;
    endcase
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [DATA_W-1:0] data);
    @(negedge clk);
    paddr   = addr;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    data = prdata;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_done();
    logic [DATA_W-1:0] status;
    status = '0;
    while (!status[1])
      apb_read(REG_STATUS, status);
  endtask

  // hold each conv beat until the sink takes it
  task automatic send_conv(input logic [LEN_W-1:0] n);
    for (int k = 0; k < int'(n); k++) begin
      @(negedge clk);
      conv_valid = 1'b1;
      conv_data  = conv_sent[k];
      @(posedge clk);
      while (!conv_ready)
        @(posedge clk);
    end
    @(negedge clk);
    conv_valid = 1'b0;
  endtask

  task automatic run_job(input logic store, input logic [1:0] sel,
                         input logic [ADDR_W-1:0] base, input logic [LEN_W-1:0] len,
                         input logic [ADDR_W-1:0] stride);
    logic [ADDR_W-1:0] addr;
    @(negedge clk);
    job_is_store = store;
    load_sel     = sel;
    job_base     = base;
    job_stride   = stride;
    job_len      = len;
    load_active  = ~store;
    store_active = store;
    apb_write(REG_BASE, DATA_W'(base));
    apb_write(REG_LEN, DATA_W'(len));
    apb_write(REG_STRIDE, DATA_W'(stride));
    apb_write(REG_CTRL, {28'h0, sel, store, 1'b1});
    if (store)
      send_conv(len);
    wait_done();
    load_active  = 1'b0;
    store_active = 1'b0;
    if (store) begin
      for (int k = 0; k < int'(len); k++) begin
        addr          = base + stride * k[ADDR_W-1:0];
        ref_mem[addr] = conv_sent[k];  // reference now holds the stored beats
      end
    end
  endtask

  initial begin
    logic [DATA_W-1:0] rdata;
    reset         = 1'b1;
    paddr         = '0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    pwdata        = '0;
    conv_valid    = 1'b0;
    conv_data     = '0;
    stall_en      = 1'b0;
    load_active   = 1'b0;
    store_active  = 1'b0;
    job_is_store  = 1'b0;
    load_sel      = LD_FEAT;
    job_base      = '0;
    job_stride    = '0;
    job_len       = '0;
    shadow_base   = '0;
    shadow_len    = '0;
    shadow_stride = '0;
    for (int i = 0; i < 8; i++)
      conv_sent[i] = $random(seed);
    for (int a = 0; a < 2**ADDR_W; a++)
      ref_mem[a] = DATA_W'(a) ^ PATTERN;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // register access and an unmapped offset
    apb_read(REG_STATUS, rdata);
    apb_write(REG_BASE, 32'h0000_1234);
    apb_write(REG_LEN, 32'h0000_0007);
    apb_write(REG_STRIDE, 32'h0000_0005);
    apb_read(REG_BASE, rdata);
    apb_read(REG_LEN, rdata);
    apb_read(REG_STRIDE, rdata);
    apb_read(BAD_ADDR, rdata);

    run_job(1'b0, LD_FEAT, 16'h0010, 16'd8, 16'd1);
    stall_en = 1'b1;  // random ready from here on
    run_job(1'b0, LD_NORM, 16'h0100, 16'd10, 16'd3);
    run_job(1'b1, LD_FEAT, ST_BASE, ST_LEN, ST_STRIDE);
    run_job(1'b0, LD_WEIGHT, ST_BASE, ST_LEN, ST_STRIDE);  // read back the stored words

    repeat (4) @(posedge clk);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/tb_memory_model.sv
// word-addressed memory model for the streamer testbench
// random grant, writes on grant, read data one cycle after a granted read
`timescale 1ns/10ps
`default_nettype none

module tb_memory_model (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [streamer_pkg::ADDR_W-1:0] addr_i,
  input  logic [streamer_pkg::DATA_W-1:0] wdata_i,
  output logic                            gnt_o,
  output logic [streamer_pkg::DATA_W-1:0] rdata_o,
  output logic                            rvalid_o
);

  import streamer_pkg::*;

  logic [DATA_W-1:0] mem [2**ADDR_W];
  logic              gnt_q     = 1'b0;
  logic              rvalid_q  = 1'b0;
  logic [DATA_W-1:0] rdata_q   = '0;
  logic              rd_hit_q  = 1'b0;  // read granted in the last cycle
  logic [DATA_W-1:0] rd_word_q = '0;
  integer            seed      = 32'h881b_056a;

  initial begin
    for (int a = 0; a < 2**ADDR_W; a++)
      mem[a] = DATA_W'(a) ^ 32'hA5A5_0000;  // every word tagged by its address
  end

  // outputs change on the falling edge only
  always @(negedge clk_i) begin
    gnt_q    <= ((($random(seed) & 32'h7fff_ffff) % 100) < 70);  // roughly 70% grant
    rvalid_q <= rd_hit_q;
    rdata_q  <= rd_word_q;
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      rd_hit_q <= 1'b0;
    end else begin
      rd_hit_q  <= req_i & gnt_q & ~we_i;
      rd_word_q <= mem[addr_i];
      if (req_i && gnt_q && we_i)
        mem[addr_i] <= wdata_i;
    end
  end

  assign gnt_o    = gnt_q;
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

//--- src/tcdm_streamer.sv
// memory streamer top
// APB-configured strided loads to feat/weight/norm and stores from conv,
// sharing one word-addressed memory port
`timescale 1ns/10ps
`default_nettype none

module tcdm_streamer (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [streamer_pkg::APB_AW-1:0] paddr_i,
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [streamer_pkg::DATA_W-1:0] pwdata_i,
  output logic [streamer_pkg::DATA_W-1:0] prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,
  output logic                            mem_req_o,
  output logic                            mem_we_o,
  output logic [streamer_pkg::ADDR_W-1:0] mem_addr_o,
  output logic [streamer_pkg::DATA_W-1:0] mem_wdata_o,
  input  logic                            mem_gnt_i,
  input  logic [streamer_pkg::DATA_W-1:0] mem_rdata_i,
  input  logic                            mem_rvalid_i,
  output logic                            feat_valid_o,
  output logic [streamer_pkg::DATA_W-1:0] feat_data_o,
  input  logic                            feat_ready_i,
  output logic                            weight_valid_o,
  output logic [streamer_pkg::DATA_W-1:0] weight_data_o,
  input  logic                            weight_ready_i,
  output logic                            norm_valid_o,
  output logic [streamer_pkg::DATA_W-1:0] norm_data_o,
  input  logic                            norm_ready_i,
  input  logic                            conv_valid_i,
  input  logic [streamer_pkg::DATA_W-1:0] conv_data_i,
  output logic                            conv_ready_o
);

  import streamer_pkg::*;

  logic              start;
  logic              store;
  logic [1:0]        ld_sel;
  logic [ADDR_W-1:0] base;
  logic [LEN_W-1:0]  len;
  logic [ADDR_W-1:0] stride;
  logic              ld_done;
  logic              st_done;
  logic              src_req;
  logic [ADDR_W-1:0] src_addr;
  logic              src_gnt;
  logic              src_valid;
  logic              src_ready;
  logic [DATA_W-1:0] src_data;
  logic              snk_req;
  logic [ADDR_W-1:0] snk_addr;
  logic [DATA_W-1:0] snk_wdata;
  logic              snk_gnt;

  streamer_regs u_regs (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .paddr_i   ( paddr_i   ),
    .psel_i    ( psel_i    ),
    .penable_i ( penable_i ),
    .pwrite_i  ( pwrite_i  ),
    .pwdata_i  ( pwdata_i  ),
    .prdata_o  ( prdata_o  ),
    .pready_o  ( pready_o  ),
    .pslverr_o ( pslverr_o ),
    .ld_done_i ( ld_done   ),
    .st_done_i ( st_done   ),
    .start_o   ( start     ),
    .store_o   ( store     ),
    .ld_sel_o  ( ld_sel    ),
    .base_o    ( base      ),
    .len_o     ( len       ),
    .stride_o  ( stride    )
  );

  tcdm_source u_source (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .start_i     ( start        ),
    .enable_i    ( ~store       ),
    .base_i      ( base         ),
    .len_i       ( len          ),
    .stride_i    ( stride       ),
    .req_o       ( src_req      ),
    .addr_o      ( src_addr     ),
    .gnt_i       ( src_gnt      ),
    .rdata_i     ( mem_rdata_i  ),
    .rvalid_i    ( mem_rvalid_i ),
    .out_valid_o ( src_valid    ),
    .out_data_o  ( src_data     ),
    .out_ready_i ( src_ready    ),
    .done_o      ( ld_done      )
  );

  tcdm_sink u_sink (
    .clk_i      ( clk_i        ),
    .reset_i    ( reset_i      ),
    .start_i    ( start        ),
    .enable_i   ( store        ),
    .base_i     ( base         ),
    .len_i      ( len          ),
    .stride_i   ( stride       ),
    .req_o      ( snk_req      ),
    .addr_o     ( snk_addr     ),
    .wdata_o    ( snk_wdata    ),
    .gnt_i      ( snk_gnt      ),
    .in_valid_i ( conv_valid_i ),
    .in_data_i  ( conv_data_i  ),
    .in_ready_o ( conv_ready_o ),
    .done_o     ( st_done      )
  );

  streamer_router u_router (
    .store_i        ( store          ),
    .ld_sel_i       ( ld_sel         ),
    .src_req_i      ( src_req        ),
    .src_addr_i     ( src_addr       ),
    .snk_req_i      ( snk_req        ),
    .snk_addr_i     ( snk_addr       ),
    .snk_wdata_i    ( snk_wdata      ),
    .src_valid_i    ( src_valid      ),
    .feat_ready_i   ( feat_ready_i   ),
    .weight_ready_i ( weight_ready_i ),
    .norm_ready_i   ( norm_ready_i   ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .mem_req_o      ( mem_req_o      ),
    .mem_we_o       ( mem_we_o       ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_wdata_o    ( mem_wdata_o    ),
    .src_gnt_o      ( src_gnt        ),
    .snk_gnt_o      ( snk_gnt        ),
    .src_ready_o    ( src_ready      ),
    .feat_valid_o   ( feat_valid_o   ),
    .weight_valid_o ( weight_valid_o ),
    .norm_valid_o   ( norm_valid_o   )
  );

  // only the selected valid qualifies the shared data
  assign feat_data_o   = src_data;
  assign weight_data_o = src_data;
  assign norm_data_o   = src_data;

endmodule

`default_nettype wire

//--- src/streamer_router.sv
// load/store router
// static mux of the memory port between the two paths and
// demux of the load stream onto feat, weight or norm
`timescale 1ns/10ps
`default_nettype none

module streamer_router (
  input  logic                            store_i,
  input  logic [1:0]                      ld_sel_i,
  input  logic                            src_req_i,
  input  logic [streamer_pkg::ADDR_W-1:0] src_addr_i,
  input  logic                            snk_req_i,
  input  logic [streamer_pkg::ADDR_W-1:0] snk_addr_i,
  input  logic [streamer_pkg::DATA_W-1:0] snk_wdata_i,
  input  logic                            src_valid_i,
  input  logic                            feat_ready_i,
  input  logic                            weight_ready_i,
  input  logic                            norm_ready_i,
  input  logic                            mem_gnt_i,
  output logic                            mem_req_o,
  output logic                            mem_we_o,
  output logic [streamer_pkg::ADDR_W-1:0] mem_addr_o,
  output logic [streamer_pkg::DATA_W-1:0] mem_wdata_o,
  output logic                            src_gnt_o,
  output logic                            snk_gnt_o,
  output logic                            src_ready_o,
  output logic                            feat_valid_o,
  output logic                            weight_valid_o,
  output logic                            norm_valid_o
);

  import streamer_pkg::*;

  // memory port goes to the sink during stores
  assign mem_req_o   = store_i ? snk_req_i  : src_req_i;
  assign mem_we_o    = store_i;
  assign mem_addr_o  = store_i ? snk_addr_i : src_addr_i;
  assign mem_wdata_o = snk_wdata_i;
  assign src_gnt_o   = ~store_i & mem_gnt_i;
  assign snk_gnt_o   = store_i & mem_gnt_i;

  assign feat_valid_o   = src_valid_i & (ld_sel_i == LD_FEAT);
  assign weight_valid_o = src_valid_i & (ld_sel_i == LD_WEIGHT);
  assign norm_valid_o   = src_valid_i & (ld_sel_i == LD_NORM);

  always_comb begin
    case (ld_sel_i)
      LD_FEAT:   src_ready_o = feat_ready_i;
      LD_WEIGHT: src_ready_o = weight_ready_i;
      LD_NORM:   src_ready_o = norm_ready_i;
      default:   src_ready_o = 1'b0;  // reserved code stalls the source
    endcase
  end

endmodule

`default_nettype wire

//--- src/tcdm_sink.sv
// memory write sink
// turns each incoming stream beat into a write at the next strided address
`timescale 1ns/10ps
`default_nettype none

module tcdm_sink (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            start_i,
  input  logic                            enable_i,
  input  logic [streamer_pkg::ADDR_W-1:0] base_i,
  input  logic [streamer_pkg::LEN_W-1:0]  len_i,
  input  logic [streamer_pkg::ADDR_W-1:0] stride_i,
  output logic                            req_o,
  output logic [streamer_pkg::ADDR_W-1:0] addr_o,
  output logic [streamer_pkg::DATA_W-1:0] wdata_o,
  input  logic                            gnt_i,
  input  logic                            in_valid_i,
  input  logic [streamer_pkg::DATA_W-1:0] in_data_i,
  output logic                            in_ready_o,
  output logic                            done_o
);

  logic launch;
  logic fire;
  logic last_addr;
  logic active_q;  // store job has words left

  assign launch = start_i & enable_i;

  stream_addressgen u_addressgen (
    .clk_i    ( clk_i     ),
    .reset_i  ( reset_i   ),
    .start_i  ( launch    ),
    .base_i   ( base_i    ),
    .len_i    ( len_i     ),
    .stride_i ( stride_i  ),
    .next_i   ( fire      ),
    .addr_o   ( addr_o    ),
    .last_o   ( last_addr )
  );

  assign req_o      = active_q & enable_i & in_valid_i;
  assign wdata_o    = in_data_i;
  assign in_ready_o = active_q & enable_i & gnt_i;  // beat leaves on grant
  assign fire       = req_o & gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i)
      active_q <= 1'b0;
    else if (launch)
      active_q <= (len_i != '0);
    else if (fire && last_addr)
      active_q <= 1'b0;
  end

  assign done_o = (fire & last_addr) | (launch & (len_i == '0));

endmodule

`default_nettype wire

//--- src/tcdm_source.sv
// memory read source
// issues strided reads and buffers the replies into a valid/ready stream,
// never requesting more than the buffer can absorb
`timescale 1ns/10ps
`default_nettype none

module tcdm_source (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            start_i,
  input  logic                            enable_i,
  input  logic [streamer_pkg::ADDR_W-1:0] base_i,
  input  logic [streamer_pkg::LEN_W-1:0]  len_i,
  input  logic [streamer_pkg::ADDR_W-1:0] stride_i,
  output logic                            req_o,
  output logic [streamer_pkg::ADDR_W-1:0] addr_o,
  input  logic                            gnt_i,
  input  logic [streamer_pkg::DATA_W-1:0] rdata_i,
  input  logic                            rvalid_i,
  output logic                            out_valid_o,
  output logic [streamer_pkg::DATA_W-1:0] out_data_o,
  input  logic                            out_ready_i,
  output logic                            done_o
);

  import streamer_pkg::*;

  logic                               launch;
  logic                               fire;
  logic                               pop;
  logic                               last_addr;
  logic                               issue_q;  // addresses left to request
  logic [LEN_W-1:0]                   beats_q;  // beats left to deliver
  logic [$clog2(SRC_DEPTH+1)-1:0]     outst_q;
  logic [$clog2(SRC_DEPTH+1)-1:0]     cnt_q;
  logic [$clog2(SRC_DEPTH)-1:0]       wr_ptr_q;
  logic [$clog2(SRC_DEPTH)-1:0]       rd_ptr_q;
  logic [DATA_W-1:0]                  buf_q [SRC_DEPTH];

  assign launch = start_i & enable_i;
  assign fire   = req_o & gnt_i;
  assign pop    = out_valid_o & out_ready_i;

  stream_addressgen u_addressgen (
    .clk_i    ( clk_i     ),
    .reset_i  ( reset_i   ),
    .start_i  ( launch    ),
    .base_i   ( base_i    ),
    .len_i    ( len_i     ),
    .stride_i ( stride_i  ),
    .next_i   ( fire      ),
    .addr_o   ( addr_o    ),
    .last_o   ( last_addr )
  );

  // reserve a buffer slot for every read in flight
  assign req_o = issue_q & enable_i & ((cnt_q + outst_q) < SRC_DEPTH);

  always_ff @(posedge clk_i) begin
    if (reset_i)
      issue_q <= 1'b0;
    else if (launch)
      issue_q <= (len_i != '0);
    else if (fire && last_addr)
      issue_q <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outst_q  <= '0;
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      case ({fire, rvalid_i})
        2'b10:   outst_q <= outst_q + 1'b1;
        2'b01:   outst_q <= outst_q - 1'b1;
        default: ;
      endcase
      case ({rvalid_i, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;
      endcase
      if (rvalid_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvalid_i)
      buf_q[wr_ptr_q] <= rdata_i;
  end

  assign out_valid_o = (cnt_q != '0);
  assign out_data_o  = buf_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i)
      beats_q <= '0;
    else if (launch)
      beats_q <= len_i;
    else if (pop && beats_q != '0)
      beats_q <= beats_q - 1'b1;
  end

  // empty jobs finish in the launch cycle
  assign done_o = (pop & (beats_q == LEN_W'(1))) | (launch & (len_i == '0));

  // memory only answers reads that were granted
  assert property (@(posedge clk_i) disable iff (reset_i) rvalid_i |-> (outst_q != '0));

endmodule

`default_nettype wire

//--- src/stream_addressgen.sv
// strided address generator
// walks base, base+stride, ... and flags the last word of the run
`timescale 1ns/10ps
`default_nettype none

module stream_addressgen (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            start_i,
  input  logic [streamer_pkg::ADDR_W-1:0] base_i,
  input  logic [streamer_pkg::LEN_W-1:0]  len_i,
  input  logic [streamer_pkg::ADDR_W-1:0] stride_i,
  input  logic                            next_i,
  output logic [streamer_pkg::ADDR_W-1:0] addr_o,
  output logic                            last_o
);

  import streamer_pkg::*;

  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  remain_q;  // words not yet consumed

  always_ff @(posedge clk_i) begin
    if (start_i)
      addr_q <= base_i;
    else if (next_i)
      addr_q <= addr_q + stride_i;  // wraps in the word space
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      remain_q <= '0;
    else if (start_i)
      remain_q <= len_i;
    else if (next_i && remain_q != '0)
      remain_q <= remain_q - 1'b1;
  end

  assign addr_o = addr_q;
  assign last_o = (remain_q == LEN_W'(1));

endmodule

`default_nettype wire

//--- src/streamer_regs.sv
// streamer register file
// APB slave holding the job configuration, launches jobs and tracks busy/done
`timescale 1ns/10ps
`default_nettype none

module streamer_regs (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [streamer_pkg::APB_AW-1:0] paddr_i,
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [streamer_pkg::DATA_W-1:0] pwdata_i,
  output logic [streamer_pkg::DATA_W-1:0] prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,
  input  logic                            ld_done_i,
  input  logic                            st_done_i,
  output logic                            start_o,
  output logic                            store_o,
  output logic [1:0]                      ld_sel_o,
  output logic [streamer_pkg::ADDR_W-1:0] base_o,
  output logic [streamer_pkg::LEN_W-1:0]  len_o,
  output logic [streamer_pkg::ADDR_W-1:0] stride_o
);

  import streamer_pkg::*;

  logic access;
  logic wr;
  logic hit;
  logic start_req;
  logic start_q;
  logic busy_q;
  logic done_q;

  assign access    = psel_i & penable_i;
  assign wr        = access & pwrite_i;
  assign hit       = paddr_i inside {REG_BASE, REG_LEN, REG_STRIDE, REG_CTRL, REG_STATUS};
  assign pready_o  = 1'b1;  // zero wait states
  assign pslverr_o = access & ~hit;

  // a start is ignored while a job runs
  assign start_req = wr & (paddr_i == REG_CTRL) & pwdata_i[CTRL_START_BIT] & ~busy_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      base_o   <= '0;
      len_o    <= '0;
      stride_o <= '0;
      store_o  <= 1'b0;
      ld_sel_o <= LD_FEAT;
    end else if (wr) begin
      case (paddr_i)
        REG_BASE:   base_o   <= pwdata_i[ADDR_W-1:0];
        REG_LEN:    len_o    <= pwdata_i[LEN_W-1:0];
        REG_STRIDE: stride_o <= pwdata_i[ADDR_W-1:0];
        REG_CTRL: begin
          // port and stream selects stay frozen during a job
          if (!busy_q) begin
            store_o  <= pwdata_i[CTRL_STORE_BIT];
            ld_sel_o <= pwdata_i[CTRL_LDSEL_LSB +: 2];
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      start_q <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= start_req;
      if (start_req) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;  // sticky until the next launch
      end else if (busy_q && (ld_done_i || st_done_i)) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  assign start_o = start_q;

  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      REG_BASE:   prdata_o[ADDR_W-1:0] = base_o;
      REG_LEN:    prdata_o[LEN_W-1:0]  = len_o;
      REG_STRIDE: prdata_o[ADDR_W-1:0] = stride_o;
      REG_CTRL: begin
        prdata_o[CTRL_STORE_BIT]      = store_o;  // start reads back as 0
        prdata_o[CTRL_LDSEL_LSB +: 2] = ld_sel_o;
      end
      REG_STATUS: prdata_o[1:0] = {done_q, busy_q};
      default: ;
    endcase
  end

  // the paths only report completion inside a job
  assert property (@(posedge clk_i) disable iff (reset_i)
    (ld_done_i || st_done_i) |-> busy_q);

endmodule

`default_nettype wire

//--- src/streamer_pkg.sv
// streamer package
// widths, APB register map and load-select codes shared by the memory streamer
`default_nettype none

package streamer_pkg;

  // datapath widths
  localparam int DATA_W = 32;  // memory and stream word
  localparam int ADDR_W = 16;  // word address
  localparam int LEN_W  = 16;  // transfer length in words
  localparam int APB_AW = 8;

  // register byte offsets
  localparam logic [APB_AW-1:0] REG_BASE   = 8'h00;
  localparam logic [APB_AW-1:0] REG_LEN    = 8'h04;
  localparam logic [APB_AW-1:0] REG_STRIDE = 8'h08;
  localparam logic [APB_AW-1:0] REG_CTRL   = 8'h0C;
  localparam logic [APB_AW-1:0] REG_STATUS = 8'h10;  // bit 0 busy, bit 1 done

  // control register fields
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_STORE_BIT = 1;  // 0 selects load
  localparam int CTRL_LDSEL_LSB = 2;  // two bits wide

  // load stream select, code 3 is reserved
  localparam logic [1:0] LD_FEAT   = 2'd0;
  localparam logic [1:0] LD_WEIGHT = 2'd1;
  localparam logic [1:0] LD_NORM   = 2'd2;

  // read data buffer in the source
  localparam int SRC_DEPTH = 2;

endpackage

`default_nettype wire
